//--- piezo.f
verilog/piezo_pkg.sv
verilog/beat_timer.sv
verilog/song_rom.sv
verilog/song_player.sv
verilog/mode_control.sv
verilog/tone_generator.sv
verilog/piezo.sv
tests/piezo_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the piezo testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f piezo.f --top-module piezo_tb -o piezo_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/piezo_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qF "*** TEST PASSED ***"; then
	exit 0
fi
exit 1

//--- tests/piezo_tb.sv
module piezo_tb import piezo_pkg::*; ();

	localparam int unsigned beat_cycles = 60000;
	localparam int unsigned beat_len = beat_cycles + 1;	// counter runs 0..beat_cycles
	localparam int unsigned mid_beat = 15000;	// room for two full tone laps
	localparam int unsigned edge_timeout = 20000;

	logic CLK;
	logic RESET;
	keys_t key;
	left_keys_t left_key;
	logic buzzer;

	int unsigned cycle = 0;
	int unsigned checks;
	int unsigned errors;
	int unsigned tests_failed;
	int seed;

	piezo #(
		.beat_cycles(beat_cycles)
	) dut0 (
		.CLK(CLK),
		.RESET(RESET),
		.key(key),
		.left_key(left_key),
		.buzzer(buzzer)
	);

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	always @(posedge CLK)
		cycle <= cycle + 1;

	////////////////////////////////////////////////////////////////////////////
	// compare and report

	task automatic check_period(input string name, input period_t got, input period_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error: %s got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_level(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error: %s got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic report_failure(input string what);
		errors++;
		$display("%s at cycle %0d", what, cycle);
	endtask

	task automatic finish_test(input string name, input int unsigned errors_before);
		if (errors == errors_before) begin
			$display("%s: ok", name);
		end else begin
			tests_failed++;
			$display("%s: %0d errors", name, errors - errors_before);
		end
	endtask

	// keyboard priority table, key 0 upward
	function automatic period_t key_note(input int unsigned k);
		case (k)
			0: return note_do;
			1: return note_re;
			2: return note_mi;
			3: return note_pa;
			4: return note_sol;
			5: return note_ra;
			6: return note_si;
			7: return note_high_do;
			default: return note_high_re;
		endcase
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// stimulus and waits

	task automatic pick_mode(input int unsigned idx);
		@(negedge CLK);
		left_key = '0;
		left_key[idx] = 1'b1;
		@(negedge CLK);
		left_key = '0;
	endtask

	task automatic tap_key(input int unsigned idx, output int unsigned start);
		@(negedge CLK);
		key = '0;
		key[idx] = 1'b1;
		@(negedge CLK);
		key = '0;
		start = cycle;	// beat 0 begins here
	endtask

	task automatic hold_keys(input keys_t value);
		@(negedge CLK);
		key = value;
		repeat (4) @(negedge CLK);	// note_cmd and buzzer settle
	endtask

	task automatic wait_cycle(input int unsigned target);
		int unsigned guard;
		guard = 0;
		while (cycle < target && guard < 10 * beat_len) begin
			@(negedge CLK);
			guard++;
		end
		if (cycle < target)
			report_failure("timeout waiting for the beat position");
	endtask

	task automatic wait_edge(output bit found, output int unsigned clocks);
		logic last;
		last = buzzer;
		clocks = 0;
		found = 1'b0;
		while (!found && clocks < edge_timeout) begin
			@(negedge CLK);
			clocks++;
			if (buzzer !== last)
				found = 1'b1;
		end
	endtask

	// clocks between two buzzer edges, after the first edge seen
	task automatic measure_tone(input period_t note);
		bit found;
		int unsigned clocks;
		wait_edge(found, clocks);
		if (found)
			wait_edge(found, clocks);
		if (!found)
			report_failure("no buzzer edge within the timeout");
		else
			check_period("buzzer edge interval", period_t'(clocks), note + 16'd2);
	endtask

	task automatic expect_silence(input int unsigned clocks);
		logic seen;
		seen = 1'b1;
		for (int i = 0; i < clocks; i++) begin
			@(negedge CLK);
			if (buzzer !== 1'b1 && seen === 1'b1)
				seen = buzzer;
		end
		check_level("buzzer", seen, 1'b1);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// tests

	task automatic test_idle();
		int unsigned e0;
		e0 = errors;
		expect_silence(2000);
		finish_test("test 1 idle after reset", e0);
	endtask

	task automatic test_keyboard_hold();
		int unsigned e0;
		e0 = errors;
		pick_mode(3);
		hold_keys(9'b000000100);
		measure_tone(note_mi);
		hold_keys(9'b000100100);	// key 2 still wins over key 5
		measure_tone(note_mi);
		hold_keys('0);
		expect_silence(2000);
		finish_test("test 2 keyboard hold", e0);
	endtask

	task automatic test_keyboard_random();
		int unsigned e0;
		int unsigned k;
		e0 = errors;
		k = $unsigned($random(seed)) % num_keys;
		hold_keys(keys_t'(1) << k);
		measure_tone(key_note(k));
		hold_keys('0);
		expect_silence(500);
		finish_test($sformatf("test 3 keyboard key %0d", k), e0);
	endtask

	task automatic test_song_one();
		int unsigned e0;
		int unsigned start;
		e0 = errors;
		pick_mode(0);
		tap_key(1, start);
		wait_cycle(start + mid_beat);
		measure_tone(note_high_re);
		wait_cycle(start + 6 * beat_len + mid_beat);
		measure_tone(note_high_mi);
		wait_cycle(start + 8 * beat_len + 10);	// tune is over
		expect_silence(2000);
		finish_test("test 4 song 1", e0);
	endtask

	task automatic test_song_stop();
		int unsigned e0;
		int unsigned start;
		e0 = errors;
		tap_key(2, start);
		wait_cycle(start + mid_beat);
		measure_tone(note_re);
		wait_cycle(start + beat_len + mid_beat);
		expect_silence(2000);	// rest step
		wait_cycle(start + 2 * beat_len + mid_beat);
		measure_tone(note_re);
		tap_key(6, start);
		wait_cycle(start + 4);
		expect_silence(2 * beat_len);
		finish_test("test 5 song 2 stopped", e0);
	endtask

	task automatic test_mode_switch();
		int unsigned e0;
		int unsigned start;
		e0 = errors;
		tap_key(0, start);
		wait_cycle(start + mid_beat);
		measure_tone(note_mi);
		pick_mode(3);	// keyboard mode mid tune
		wait_cycle(cycle + 4);
		expect_silence(beat_len);
		hold_keys(9'b000010000);
		measure_tone(note_sol);
		hold_keys('0);
		expect_silence(2000);
		finish_test("test 6 song to keyboard", e0);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// main sequence

	initial begin
		seed = 32'h84ce;
		RESET = 1'b1;
		key = '0;
		left_key = '0;
		checks = 0;
		errors = 0;
		tests_failed = 0;
		repeat (5) @(negedge CLK);
		RESET = 1'b0;

		test_idle();
		test_keyboard_hold();
		test_keyboard_random();
		test_song_one();
		test_song_stop();
		test_mode_switch();

		$display("tests 6, failed %0d, checks %0d, errors %0d", tests_failed, checks, errors);
		if (errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

//--- verilog/beat_timer.sv
module beat_timer import piezo_pkg::*; #(
	parameter int unsigned beat_cycles = beat_cycles_default
) (
	input logic CLK,
	input logic RESET,
	input keys_t key,
	output logic beat,
	output step_t step
);

	logic [$clog2(beat_cycles + 1) - 1:0] cnt;

	assign beat = (cnt == ($bits(cnt))'(beat_cycles));

	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			cnt <= '0;
			step <= '0;
		end else if (|key) begin	// any press restarts on a full beat
			cnt <= '0;
			step <= '0;
		end else begin
			if (beat)
				cnt <= '0;
			else
				cnt <= cnt + 1'b1;
			if (beat) begin
				if (step == step_t'(step_wrap))
					step <= '0;
				else
					step <= step + 1'b1;
			end
		end
	end

endmodule

//--- verilog/mode_control.sv
module mode_control import piezo_pkg::*; (
	input logic CLK,
	input logic RESET,
	input left_keys_t left_key,
	input keys_t key,
	input note_cmd_t song_cmd,
	output logic song_enable,
	output note_cmd_t note_cmd
);

	mode_t mode;
	note_cmd_t kb_cmd;

	////////////////////////////////////////////////////////////////////////////
	// mode latch, left keys 1 and 2 have no function here

	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET)
			mode <= mode_none;
		else if (left_key[0])
			mode <= mode_song;
		else if (left_key[3])
			mode <= mode_keyboard;
	end

	assign song_enable = (mode == mode_song);

	// keyboard mode, lowest held key sounds
	always_comb begin
		kb_cmd = '0;
		for (int i = num_keys - 1; i >= 0; i--) begin
			if (key[i]) begin
				kb_cmd.sound = 1'b1;
				kb_cmd.period = key_periods[i];
			end
		end
	end

	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			note_cmd <= '0;
		end else begin
			case (mode)
				mode_song: note_cmd <= song_cmd;
				mode_keyboard: note_cmd <= kb_cmd;
				default: note_cmd <= '0;	// silent until a mode is picked
			endcase
		end
	end

endmodule

//--- verilog/piezo.sv
module piezo import piezo_pkg::*; #(
	parameter int unsigned beat_cycles = beat_cycles_default
) (
	input logic CLK,
	input logic RESET,
	input keys_t key,
	input left_keys_t left_key,
	output logic buzzer
);

	step_t step;
	logic song_enable;
	note_cmd_t song_cmd;
	note_cmd_t note_cmd;

	beat_timer #(
		.beat_cycles(beat_cycles)
	) u_beat (
		.CLK(CLK),
		.RESET(RESET),
		.key(key),
		.beat(),	// only the step count leaves the timer
		.step(step)
	);

	song_player u_song (
		.CLK(CLK),
		.RESET(RESET),
		.enable(song_enable),
		.key(key),
		.step(step),
		.song_cmd(song_cmd)
	);

	mode_control u_mode (
		.CLK(CLK),
		.RESET(RESET),
		.left_key(left_key),
		.key(key),
		.song_cmd(song_cmd),
		.song_enable(song_enable),
		.note_cmd(note_cmd)
	);

	tone_generator u_tone (
		.CLK(CLK),
		.RESET(RESET),
		.note_cmd(note_cmd),
		.buzzer(buzzer)
	);

endmodule

//--- verilog/piezo_pkg.sv
package piezo_pkg;

	////////////////////////////////////////////////////////////////////////////
	// sizes and timing

	localparam int unsigned beat_cycles_default = 6000000;	// clocks per beat on the board
	localparam int unsigned step_wrap = 64;
	localparam int unsigned num_keys = 9;
	localparam int unsigned num_left_keys = 4;
	localparam int unsigned num_songs = 4;

	typedef logic [15:0] period_t;	// half-period in clocks, minus two
	typedef logic [6:0] step_t;
	typedef logic [$clog2(num_songs) - 1:0] song_id_t;
	typedef logic [num_keys - 1:0] keys_t;
	typedef logic [num_left_keys - 1:0] left_keys_t;

	typedef enum logic [1:0] {
		mode_none,
		mode_song,
		mode_keyboard
	} mode_t;

	typedef struct packed {
		logic sound;	// buzzer toggles while set
		period_t period;
	} note_cmd_t;

	////////////////////////////////////////////////////////////////////////////
	// note periods

	localparam period_t note_do = 16'd11659;
	localparam period_t note_re = 16'd10388;
	localparam period_t note_mi = 16'd9253;
	localparam period_t note_pa = 16'd8736;
	localparam period_t note_sol = 16'd7782;
	localparam period_t note_ra = 16'd6929;
	localparam period_t note_si = 16'd6175;
	localparam period_t note_high_do = 16'd5827;
	localparam period_t note_high_re = 16'd5192;
	localparam period_t note_high_mi = 16'd4625;

	// keyboard mode, key 0 upward
	localparam period_t key_periods [num_keys] = '{
		note_do, note_re, note_mi, note_pa, note_sol,
		note_ra, note_si, note_high_do, note_high_re
	};

	// song bank, one entry per beat, "-" is a rest
	// 0: mi mi mi re do do re re mi - mi - mi mi mi mi
	// 1: hre hre hre hre hre hre hmi hre
	// 2: re - re - re re re re mi mi sol - sol sol sol sol
	// 3: hdo hdo hdo hdo hdo sol hdo hre

endpackage

//--- verilog/song_player.sv
module song_player import piezo_pkg::*; (
	input logic CLK,
	input logic RESET,
	input logic enable,
	input keys_t key,
	input step_t step,
	output note_cmd_t song_cmd
);

	logic active;
	song_id_t song_id;
	song_id_t start_id;
	logic start_key;
	logic stop_key;
	logic playing;
	note_cmd_t rom_cmd;
	step_t length;

	song_rom u_rom (
		.song(song_id),
		.step(step),
		.cmd(rom_cmd),
		.length(length)
	);

	assign start_key = |key[num_songs - 1:0];
	assign stop_key = |key[num_keys - 1:num_songs];	// keys without a tune just stop

	// lowest song key wins
	always_comb begin
		start_id = '0;
		for (int i = num_songs - 1; i >= 0; i--) begin
			if (key[i])
				start_id = song_id_t'(i);
		end
	end

	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			active <= 1'b0;
			song_id <= '0;
		end else if (!enable || stop_key) begin
			active <= 1'b0;
		end else if (start_key) begin
			active <= 1'b1;
			song_id <= start_id;
		end else if (step >= length) begin
			active <= 1'b0;	// past the last step
		end
	end

	assign playing = active && (step < length);
	assign song_cmd = playing ? rom_cmd : '0;

endmodule

//--- verilog/song_rom.sv
module song_rom import piezo_pkg::*; (
	input song_id_t song,
	input step_t step,
	output note_cmd_t cmd,
	output step_t length
);

	function automatic note_cmd_t tone(input period_t p);
		note_cmd_t c;
		c.sound = 1'b1;
		c.period = p;
		return c;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// tune tables

	always_comb begin
		cmd = '0;	// rest unless a step says otherwise
		length = '0;
		case (song)
			2'd0: begin
				length = 7'd16;
				case (step)
					7'd0: cmd = tone(note_mi);
					7'd1: cmd = tone(note_mi);
					7'd2: cmd = tone(note_mi);
					7'd3: cmd = tone(note_re);
					7'd4: cmd = tone(note_do);
					7'd5: cmd = tone(note_do);
					7'd6: cmd = tone(note_re);
					7'd7: cmd = tone(note_re);
					7'd8: cmd = tone(note_mi);
					7'd9: cmd.sound = 1'b0;	// rest
					7'd10: cmd = tone(note_mi);
					7'd11: cmd.sound = 1'b0;	// rest
					7'd12: cmd = tone(note_mi);
					7'd13: cmd = tone(note_mi);
					7'd14: cmd = tone(note_mi);
					7'd15: cmd = tone(note_mi);
					default: cmd = '0;
				endcase
			end
			2'd1: begin
				length = 7'd8;
				case (step)
					7'd0: cmd = tone(note_high_re);
					7'd1: cmd = tone(note_high_re);
					7'd2: cmd = tone(note_high_re);
					7'd3: cmd = tone(note_high_re);
					7'd4: cmd = tone(note_high_re);
					7'd5: cmd = tone(note_high_re);
					7'd6: cmd = tone(note_high_mi);
					7'd7: cmd = tone(note_high_re);
					default: cmd = '0;
				endcase
			end
			2'd2: begin
				length = 7'd16;
				case (step)
					7'd0: cmd = tone(note_re);
					7'd1: cmd.sound = 1'b0;	// rest
					7'd2: cmd = tone(note_re);
					7'd3: cmd.sound = 1'b0;	// rest
					7'd4: cmd = tone(note_re);
					7'd5: cmd = tone(note_re);
					7'd6: cmd = tone(note_re);
					7'd7: cmd = tone(note_re);
					7'd8: cmd = tone(note_mi);
					7'd9: cmd = tone(note_mi);
					7'd10: cmd = tone(note_sol);
					7'd11: cmd.sound = 1'b0;	// rest
					7'd12: cmd = tone(note_sol);
					7'd13: cmd = tone(note_sol);
					7'd14: cmd = tone(note_sol);
					7'd15: cmd = tone(note_sol);
					default: cmd = '0;
				endcase
			end
			default: begin
				length = 7'd8;
				case (step)
					7'd0: cmd = tone(note_high_do);
					7'd1: cmd = tone(note_high_do);
					7'd2: cmd = tone(note_high_do);
					7'd3: cmd = tone(note_high_do);
					7'd4: cmd = tone(note_high_do);
					7'd5: cmd = tone(note_sol);
					7'd6: cmd = tone(note_high_do);
					7'd7: cmd = tone(note_high_re);
					default: cmd = '0;
				endcase
			end
		endcase
	end

endmodule

//--- verilog/tone_generator.sv
module tone_generator import piezo_pkg::*; (
	input logic CLK,
	input logic RESET,
	input note_cmd_t note_cmd,
	output logic buzzer
);

	period_t cnt;

	// one lap is period + 2 clocks
	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET)
			cnt <= '0;
		else if (cnt > note_cmd.period)
			cnt <= '0;
		else
			cnt <= cnt + 1'b1;
	end

	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET)
			buzzer <= 1'b1;	// idle high
		else if (!note_cmd.sound)
			buzzer <= 1'b1;
		else if (cnt == 16'd1)
			buzzer <= ~buzzer;
	end

endmodule
